//--- Makefile
SIM = obj_dir/Vint_cluster_tb

.PHONY: all run lint clean

all: run

$(SIM): build.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module int_cluster_tb -o Vint_cluster_tb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "Test passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module int_cluster

clean:
	rm -rf obj_dir sim.log

//--- build.f
verilog/int_pkg.sv
verilog/int_decode.sv
verilog/int_issue_queue.sv
verilog/int_alu.sv
verilog/int_result.sv
verilog/int_cluster.sv
verification/int_cluster_tb.sv

//--- verification/int_cluster_tb.sv
module int_cluster_tb import int_pkg::*; ();

    localparam int      CLK_PERIOD  = 4;
    localparam int      TEST_CYCLES = 120;   // rough length of all tests together
    localparam rob_id_t READY_TAG   = 5'd0;  // never used as an instruction tag
    localparam rob_id_t LOAD_TAG    = 5'd31;

    logic      clk;
    logic      arst_n;
    logic      dispatch_valid;
    logic      dispatch_ready;
    instr_u    dispatch_instr;
    rob_id_t   dispatch_rob_id;
    rob_id_t   dispatch_src1_rob_id;
    logic      dispatch_src1_ready;
    reg_data_t dispatch_src1_data;
    rob_id_t   dispatch_src2_rob_id;
    logic      dispatch_src2_ready;
    reg_data_t dispatch_src2_data;
    logic      ld_broadcast_valid;
    rob_id_t   ld_broadcast_rob_id;
    reg_data_t ld_broadcast_data;
    logic      fetch_redirect_valid;
    logic      result_valid;
    rob_id_t   result_rob_id;
    reg_data_t result_data;

    // scoreboard, one slot per rob id
    logic      pending    [32];
    logic      flushed    [32];
    reg_data_t exp_data   [32];
    int        acc_cycle  [32];
    int        done_cycle [32];
    int        outstanding = 0;
    int        cycle       = 0;
    int        errors      = 0;
    int        checks      = 0;
    integer    seed        = 99;
    rob_id_t   next_id     = 5'd1;
    rob_id_t   last_rob_id = '0;

    int_cluster #(
        .N_ENTRIES (4)
    ) dut_i (
        .clk                  (clk),
        .arst_n               (arst_n),
        .dispatch_valid       (dispatch_valid),
        .dispatch_ready       (dispatch_ready),
        .dispatch_instr       (dispatch_instr),
        .dispatch_rob_id      (dispatch_rob_id),
        .dispatch_src1_rob_id (dispatch_src1_rob_id),
        .dispatch_src1_ready  (dispatch_src1_ready),
        .dispatch_src1_data   (dispatch_src1_data),
        .dispatch_src2_rob_id (dispatch_src2_rob_id),
        .dispatch_src2_ready  (dispatch_src2_ready),
        .dispatch_src2_data   (dispatch_src2_data),
        .ld_broadcast_valid   (ld_broadcast_valid),
        .ld_broadcast_rob_id  (ld_broadcast_rob_id),
        .ld_broadcast_data    (ld_broadcast_data),
        .fetch_redirect_valid (fetch_redirect_valid),
        .result_valid         (result_valid),
        .result_rob_id        (result_rob_id),
        .result_data          (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;   // read only on falling edges

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rob_id(input string name, input rob_id_t got, input rob_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic instr_u r_instr(input logic [6:0] f7, input logic [2:0] f3);
        instr_u ins;
        ins.r_fmt = '{funct7: f7, rs2: 5'd2, rs1: 5'd1, funct3: f3, rd: 5'd3,
                      opcode: 7'b0110011};
        return ins;
    endfunction

    function automatic instr_u i_instr(input logic [11:0] imm12, input logic [2:0] f3);
        instr_u ins;
        ins.i_fmt = '{imm12: imm12, rs1: 5'd1, funct3: f3, rd: 5'd3, opcode: 7'b0010011};
        return ins;
    endfunction

    function automatic instr_u lui_instr(input logic [19:0] imm20);
        instr_u ins;
        ins.i_fmt = '{imm12: imm20[19:8], rs1: imm20[7:3], funct3: imm20[2:0], rd: 5'd3,
                      opcode: 7'b0110111};
        return ins;
    endfunction

    // RV32I semantics straight from the encoding
    function automatic reg_data_t model(input instr_u ins, input reg_data_t a, input reg_data_t b);
        reg_data_t  imm;
        logic [4:0] sh;
        logic       alt;
        imm = {{20{ins.i_fmt.imm12[11]}}, ins.i_fmt.imm12};
        alt = ins.r_fmt.funct7[5];   // bit 30
        if (ins.r_fmt.opcode == 7'b0110111)
            return reg_data_t'(ins) & 32'hffff_f000;   // upper 20 bits, low 12 zero
        if (ins.r_fmt.opcode == 7'b0010011) b = imm;
        sh = b[4:0];
        case (ins.r_fmt.funct3)
            3'd0: return (ins.r_fmt.opcode == 7'b0110011 && alt) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? reg_data_t'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // drives one dispatch on the falling edge, returns right after the accepting edge
    task automatic send(input instr_u ins, input logic s1_rdy, input rob_id_t s1_tag,
                        input reg_data_t s1, input logic s2_rdy, input rob_id_t s2_tag,
                        input reg_data_t s2, input reg_data_t exp, output rob_id_t id);
        id      = next_id;
        next_id = (next_id == 5'd30) ? 5'd1 : next_id + 5'd1;
        @(negedge clk);
        pending[id]          = 1'b1;
        flushed[id]          = 1'b0;
        exp_data[id]         = exp;
        outstanding++;
        dispatch_valid       = 1'b1;
        dispatch_instr       = ins;
        dispatch_rob_id      = id;
        dispatch_src1_ready  = s1_rdy;
        dispatch_src1_rob_id = s1_tag;
        dispatch_src1_data   = s1;
        dispatch_src2_ready  = s2_rdy;
        dispatch_src2_rob_id = s2_tag;
        dispatch_src2_data   = s2;
        while (!dispatch_ready) @(negedge clk);
        acc_cycle[id] = cycle + 1;
        @(posedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            dispatch_valid = 1'b0;
        end
    endtask

    task automatic wait_all();
        idle(1);
        while (outstanding != 0) @(posedge clk);   // watchdog catches a lost result
    endtask

    task automatic load_broadcast(input rob_id_t tag, input reg_data_t data);
        @(negedge clk);
        ld_broadcast_valid  = 1'b1;
        ld_broadcast_rob_id = tag;
        ld_broadcast_data   = data;
        @(negedge clk);
        ld_broadcast_valid  = 1'b0;
    endtask

    task automatic r_type_ops();
        logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        logic [6:0] f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        instr_u     ins;
        reg_data_t  a;
        reg_data_t  b;
        rob_id_t    id;
        for (int i = 0; i < 10; i++) begin
            ins = r_instr(f7s[i], f3s[i]);
            a   = $random(seed);
            b   = $random(seed);
            send(ins, 1'b1, READY_TAG, a, 1'b1, READY_TAG, b, model(ins, a, b), id);
            wait_all();
            check_rob_id("result_rob_id", last_rob_id, id);
            check_cycles("lone latency", done_cycle[id] - acc_cycle[id], 2);
        end
    endtask

    task automatic i_type_and_lui();
        logic [11:0] imms [10] = '{12'hffb, 12'hfff, 12'hfff, 12'hfff, 12'h800,
                                   12'hf0f, 12'h007, 12'h00d, 12'h41f, 12'h404};
        logic [2:0]  f3s  [10] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5, 3'd5};
        instr_u      ins;
        reg_data_t   a;
        reg_data_t   b;
        rob_id_t     id;
        for (int i = 0; i < 10; i++) begin
            ins = i_instr(imms[i], f3s[i]);
            a   = $random(seed);
            b   = $random(seed);   // unused source, must not leak into the result
            if (i >= 8) a = a | 32'h8000_0000;   // negative value for srai
            send(ins, 1'b1, READY_TAG, a, 1'b1, READY_TAG, b, model(ins, a, b), id);
        end
        ins = lui_instr(20'habcde);
        a   = $random(seed);
        send(ins, 1'b0, LOAD_TAG, a, 1'b1, READY_TAG, a, model(ins, a, a), id);
        wait_all();
    endtask

    task automatic wakeup_chain();
        instr_u    ins;
        reg_data_t a;
        reg_data_t exp;
        rob_id_t   ids [3];
        ins = r_instr(7'h00, 3'd0);
        a   = $random(seed);
        exp = a;
        for (int i = 0; i < 3; i++) begin
            a   = $random(seed);
            exp = model(ins, exp, a);
            if (i == 0)
                send(ins, 1'b1, READY_TAG, exp - a, 1'b1, READY_TAG, a, exp, ids[i]);
            else
                send(ins, 1'b0, ids[i-1], 32'hdead_beef, 1'b1, READY_TAG, a, exp, ids[i]);
        end
        wait_all();
        check_cycles("chain gap 1", done_cycle[ids[1]] - done_cycle[ids[0]], 1);
        check_cycles("chain gap 2", done_cycle[ids[2]] - done_cycle[ids[1]], 1);
    endtask

    task automatic load_capture();
        instr_u    ins_a;
        instr_u    ins_b;
        reg_data_t ld;
        reg_data_t x;
        reg_data_t y;
        rob_id_t   id;
        ins_a = r_instr(7'h20, 3'd0);   // sub, src1 from the load
        ins_b = r_instr(7'h00, 3'd3);   // sltu, src2 from the load
        ld    = $random(seed);
        x     = $random(seed);
        y     = $random(seed);
        send(ins_a, 1'b0, LOAD_TAG, 32'h0bad_0bad, 1'b1, READY_TAG, x, model(ins_a, ld, x), id);
        send(ins_b, 1'b1, READY_TAG, y, 1'b0, LOAD_TAG, 32'h0bad_0bad, model(ins_b, y, ld), id);
        idle(3);
        check_cycles("results before load", outstanding, 2);
        load_broadcast(LOAD_TAG, ld);
        wait_all();
    endtask

    task automatic backpressure();
        logic [6:0] f7s [4] = '{7'h00, 7'h20, 7'h00, 7'h00};
        logic [2:0] f3s [4] = '{3'd0, 3'd0, 3'd6, 3'd7};
        instr_u     ins;
        reg_data_t  ld;
        reg_data_t  b;
        rob_id_t    id;
        ld = $random(seed);
        for (int i = 0; i < 4; i++) begin
            ins = r_instr(f7s[i], f3s[i]);
            b   = $random(seed);
            send(ins, 1'b0, LOAD_TAG, 32'h0, 1'b1, READY_TAG, b, model(ins, ld, b), id);
        end
        ins = r_instr(7'h00, 3'd4);
        b   = $random(seed);
        fork
            send(ins, 1'b1, READY_TAG, ld, 1'b1, READY_TAG, b, model(ins, ld, b), id);
            begin
                repeat (3) begin
                    @(negedge clk);
                    check_flag("dispatch_ready while full", dispatch_ready, 1'b0);
                end
                load_broadcast(LOAD_TAG, ld);
            end
        join
        wait_all();
    endtask

    task automatic flush_waiting();
        instr_u    ins;
        reg_data_t a;
        reg_data_t b;
        rob_id_t   ids [4];
        rob_id_t   id;
        ins = r_instr(7'h00, 3'd0);
        for (int i = 0; i < 4; i++) begin
            send(ins, 1'b0, LOAD_TAG, 32'h0, 1'b1, READY_TAG, 32'h1, 32'h0, ids[i]);
        end
        @(negedge clk);
        check_flag("dispatch_ready before flush", dispatch_ready, 1'b0);
        dispatch_valid       = 1'b0;
        fetch_redirect_valid = 1'b1;
        @(negedge clk);
        fetch_redirect_valid = 1'b0;
        for (int i = 0; i < 4; i++) begin
            pending[ids[i]] = 1'b0;
            flushed[ids[i]] = 1'b1;
            outstanding--;
        end
        check_flag("dispatch_ready after flush", dispatch_ready, 1'b1);
        load_broadcast(LOAD_TAG, 32'h5a5a_5a5a);   // would wake any entry that survived
        a = $random(seed);
        b = $random(seed);
        send(ins, 1'b1, READY_TAG, a, 1'b1, READY_TAG, b, model(ins, a, b), id);
        wait_all();
        idle(6);   // room for a stray flushed result to show up
    endtask

    // results come from registers, so the falling edge sees them settled
    always @(negedge clk) begin
        rob_id_t id;
        id = result_rob_id;
        if (arst_n && result_valid) begin
            if (flushed[id]) begin
                errors++;
                $display("t=%0t result reported for flushed rob id %0d", $time, id);
            end else if (!pending[id]) begin
                errors++;
                $display("t=%0t result for rob id %0d that was not outstanding", $time, id);
            end else begin
                check_data("result_data", result_data, exp_data[id]);
                pending[id]    = 1'b0;
                done_cycle[id] = cycle;
                last_rob_id    = id;
                outstanding--;
            end
        end
    end

    initial begin
        #(TEST_CYCLES * 20 * CLK_PERIOD);
        $display("timeout, %0d dispatched results never arrived", outstanding);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        arst_n               = 1'b0;
        dispatch_valid       = 1'b0;
        dispatch_instr       = '0;
        dispatch_rob_id      = '0;
        dispatch_src1_rob_id = '0;
        dispatch_src1_ready  = 1'b0;
        dispatch_src1_data   = '0;
        dispatch_src2_rob_id = '0;
        dispatch_src2_ready  = 1'b0;
        dispatch_src2_data   = '0;
        ld_broadcast_valid   = 1'b0;
        ld_broadcast_rob_id  = '0;
        ld_broadcast_data    = '0;
        fetch_redirect_valid = 1'b0;
        for (int i = 0; i < 32; i++) begin
            pending[i] = 1'b0;
            flushed[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk) arst_n = 1'b1;
        check_flag("dispatch_ready after reset", dispatch_ready, 1'b1);
        check_flag("result_valid after reset", result_valid, 1'b0);
        r_type_ops();
        i_type_and_lui();
        wakeup_chain();
        load_capture();
        backpressure();
        flush_waiting();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog/int_alu.sv
module int_alu import int_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      exe_valid,
    input  rob_id_t   exe_rob_id,
    input  alu_op_e   exe_op,
    input  reg_data_t exe_src1,
    input  reg_data_t exe_src2,
    input  reg_data_t exe_imm,
    input  logic      exe_use_imm,
    output logic      alu_broadcast_valid,
    output rob_id_t   alu_broadcast_rob_id,
    output reg_data_t alu_broadcast_data
);

    reg_data_t  operand_b;
    logic [4:0] shamt;
    reg_data_t  result;

    assign operand_b = exe_use_imm ? exe_imm : exe_src2;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (exe_op)
            ALU_ADD, ALU_ADDI:
                result = exe_src1 + operand_b;
            ALU_SUB:
                result = exe_src1 - operand_b;
            ALU_SLL, ALU_SLLI:
                result = exe_src1 << shamt;
            ALU_SLT, ALU_SLTI:
                result = {{(XLEN-1){1'b0}}, $signed(exe_src1) < $signed(operand_b)};
            ALU_SLTU, ALU_SLTIU:
                result = {{(XLEN-1){1'b0}}, exe_src1 < operand_b};
            ALU_XOR, ALU_XORI:
                result = exe_src1 ^ operand_b;
            ALU_SRL, ALU_SRLI:
                result = exe_src1 >> shamt;
            ALU_SRA, ALU_SRAI:
                result = reg_data_t'($signed(exe_src1) >>> shamt);
            ALU_OR, ALU_ORI:
                result = exe_src1 | operand_b;
            ALU_AND, ALU_ANDI:
                result = exe_src1 & operand_b;
            ALU_LUI:
                result = operand_b;   // upper immediate already shifted
            default:
                result = '0;
        endcase
    end

    // result leaves in the same cycle the issue register holds the op
    assign alu_broadcast_valid  = exe_valid;
    assign alu_broadcast_rob_id = exe_rob_id;
    assign alu_broadcast_data   = result;

    a_known_op: assert property (@(posedge clk) disable iff (!arst_n)
        exe_valid |-> exe_op inside {[ALU_ADD:ALU_LUI]});

endmodule

//--- verilog/int_cluster.sv
module int_cluster import int_pkg::*; #(
    parameter int N_ENTRIES = 8
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      dispatch_valid,
    output logic      dispatch_ready,
    input  instr_u    dispatch_instr,
    input  rob_id_t   dispatch_rob_id,
    input  rob_id_t   dispatch_src1_rob_id,
    input  logic      dispatch_src1_ready,
    input  reg_data_t dispatch_src1_data,
    input  rob_id_t   dispatch_src2_rob_id,
    input  logic      dispatch_src2_ready,
    input  reg_data_t dispatch_src2_data,
    input  logic      ld_broadcast_valid,
    input  rob_id_t   ld_broadcast_rob_id,
    input  reg_data_t ld_broadcast_data,
    input  logic      fetch_redirect_valid,
    output logic      result_valid,
    output rob_id_t   result_rob_id,
    output reg_data_t result_data
);

    alu_op_e   op;
    reg_data_t imm;
    logic      use_imm;
    logic      src2_used;
    logic      exe_valid;
    rob_id_t   exe_rob_id;
    alu_op_e   exe_op;
    reg_data_t exe_src1;
    reg_data_t exe_src2;
    reg_data_t exe_imm;
    logic      exe_use_imm;
    logic      alu_broadcast_valid;
    rob_id_t   alu_broadcast_rob_id;
    reg_data_t alu_broadcast_data;

    int_decode decode_i (
        .instr     (dispatch_instr),
        .op        (op),
        .imm       (imm),
        .use_imm   (use_imm),
        .src2_used (src2_used)
    );

    int_issue_queue #(
        .N_ENTRIES (N_ENTRIES)
    ) issue_queue_i (
        .clk                  (clk),
        .arst_n               (arst_n),
        .dispatch_valid       (dispatch_valid),
        .dispatch_ready       (dispatch_ready),
        .dispatch_rob_id      (dispatch_rob_id),
        .dispatch_src1_rob_id (dispatch_src1_rob_id),
        .dispatch_src1_ready  (dispatch_src1_ready),
        .dispatch_src1_data   (dispatch_src1_data),
        .dispatch_src2_rob_id (dispatch_src2_rob_id),
        .dispatch_src2_ready  (dispatch_src2_ready),
        .dispatch_src2_data   (dispatch_src2_data),
        .op                   (op),
        .imm                  (imm),
        .use_imm              (use_imm),
        .src2_used            (src2_used),
        .alu_broadcast_valid  (alu_broadcast_valid),
        .alu_broadcast_rob_id (alu_broadcast_rob_id),
        .alu_broadcast_data   (alu_broadcast_data),
        .ld_broadcast_valid   (ld_broadcast_valid),
        .ld_broadcast_rob_id  (ld_broadcast_rob_id),
        .ld_broadcast_data    (ld_broadcast_data),
        .fetch_redirect_valid (fetch_redirect_valid),
        .exe_valid            (exe_valid),
        .exe_rob_id           (exe_rob_id),
        .exe_op               (exe_op),
        .exe_src1             (exe_src1),
        .exe_src2             (exe_src2),
        .exe_imm              (exe_imm),
        .exe_use_imm          (exe_use_imm)
    );

    int_alu alu_i (
        .clk                  (clk),
        .arst_n               (arst_n),
        .exe_valid            (exe_valid),
        .exe_rob_id           (exe_rob_id),
        .exe_op               (exe_op),
        .exe_src1             (exe_src1),
        .exe_src2             (exe_src2),
        .exe_imm              (exe_imm),
        .exe_use_imm          (exe_use_imm),
        .alu_broadcast_valid  (alu_broadcast_valid),
        .alu_broadcast_rob_id (alu_broadcast_rob_id),
        .alu_broadcast_data   (alu_broadcast_data)
    );

    int_result result_i (
        .clk                  (clk),
        .arst_n               (arst_n),
        .fetch_redirect_valid (fetch_redirect_valid),
        .alu_broadcast_valid  (alu_broadcast_valid),
        .alu_broadcast_rob_id (alu_broadcast_rob_id),
        .alu_broadcast_data   (alu_broadcast_data),
        .result_valid         (result_valid),
        .result_rob_id        (result_rob_id),
        .result_data          (result_data)
    );

endmodule

//--- verilog/int_decode.sv
module int_decode import int_pkg::*; (
    input  instr_u    instr,
    output alu_op_e   op,
    output reg_data_t imm,
    output logic      use_imm,
    output logic      src2_used
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    reg_data_t imm_sext;
    reg_data_t imm_shamt;
    logic      alt_r;   // instr bit 30 in the R view
    logic      alt_i;   // same bit, seen from the immediate

    assign imm_sext  = {{(XLEN-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
    assign imm_shamt = {{(XLEN-5){1'b0}}, instr.i_fmt.imm12[4:0]};
    assign alt_r     = instr.r_fmt.funct7[5];
    assign alt_i     = instr.i_fmt.imm12[10];

    always_comb begin
        op        = ALU_ADD;   // unknown opcodes fall back to add
        imm       = '0;
        use_imm   = 1'b0;
        src2_used = 1'b1;
        case (instr.r_fmt.opcode)
            OPC_OP: begin
                case (instr.r_fmt.funct3)
                    3'd0: op = alt_r ? ALU_SUB : ALU_ADD;
                    3'd1: op = ALU_SLL;
                    3'd2: op = ALU_SLT;
                    3'd3: op = ALU_SLTU;
                    3'd4: op = ALU_XOR;
                    3'd5: op = alt_r ? ALU_SRA : ALU_SRL;
                    3'd6: op = ALU_OR;
                    default: op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                use_imm   = 1'b1;
                src2_used = 1'b0;
                imm       = imm_sext;
                case (instr.r_fmt.funct3)
                    3'd0: op = ALU_ADDI;
                    3'd1: begin
                        op  = ALU_SLLI;
                        imm = imm_shamt;
                    end
                    3'd2: op = ALU_SLTI;
                    3'd3: op = ALU_SLTIU;
                    3'd4: op = ALU_XORI;
                    3'd5: begin
                        op  = alt_i ? ALU_SRAI : ALU_SRLI;
                        imm = imm_shamt;
                    end
                    3'd6: op = ALU_ORI;
                    default: op = ALU_ANDI;
                endcase
            end
            OPC_LUI: begin
                op        = ALU_LUI;
                use_imm   = 1'b1;
                src2_used = 1'b0;   // src1 is dropped in the queue
                imm       = {instr.i_fmt.imm12, instr.i_fmt.rs1, instr.i_fmt.funct3, 12'b0};
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/int_issue_queue.sv
module int_issue_queue import int_pkg::*; #(
    parameter int N_ENTRIES = 8
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      dispatch_valid,
    output logic      dispatch_ready,
    input  rob_id_t   dispatch_rob_id,
    input  rob_id_t   dispatch_src1_rob_id,
    input  logic      dispatch_src1_ready,
    input  reg_data_t dispatch_src1_data,
    input  rob_id_t   dispatch_src2_rob_id,
    input  logic      dispatch_src2_ready,
    input  reg_data_t dispatch_src2_data,
    input  alu_op_e   op,
    input  reg_data_t imm,
    input  logic      use_imm,
    input  logic      src2_used,
    input  logic      alu_broadcast_valid,
    input  rob_id_t   alu_broadcast_rob_id,
    input  reg_data_t alu_broadcast_data,
    input  logic      ld_broadcast_valid,
    input  rob_id_t   ld_broadcast_rob_id,
    input  reg_data_t ld_broadcast_data,
    input  logic      fetch_redirect_valid,
    output logic      exe_valid,
    output rob_id_t   exe_rob_id,
    output alu_op_e   exe_op,
    output reg_data_t exe_src1,
    output reg_data_t exe_src2,
    output reg_data_t exe_imm,
    output logic      exe_use_imm
);

    localparam int CNT_W = $clog2(N_ENTRIES + 1);

    iiq_entry_t           entries      [N_ENTRIES];   // index 0 is the oldest
    iiq_entry_t           entries_next [N_ENTRIES];
    iiq_entry_t           new_entry;
    iiq_entry_t           pick;
    logic [CNT_W-1:0]     count;
    logic [CNT_W-1:0]     wr_idx;
    logic [N_ENTRIES-1:0] entry_ready;
    logic [N_ENTRIES-1:0] sel_onehot;
    logic [N_ENTRIES-1:0] shift_down;
    logic                 issue_fire;
    logic                 dispatch_fire;

    // alu result wins over load
    function automatic reg_data_t bypass(rob_id_t tag, reg_data_t data);
        if (alu_broadcast_valid && alu_broadcast_rob_id == tag) return alu_broadcast_data;
        if (ld_broadcast_valid && ld_broadcast_rob_id == tag) return ld_broadcast_data;
        return data;
    endfunction

    // returns {ready, data} of one source after wake-up and capture
    function automatic logic [XLEN:0] capture(rob_id_t tag, logic ready, reg_data_t data);
        logic alu_hit;
        logic ld_hit;
        logic wake_hit;
        alu_hit  = alu_broadcast_valid && alu_broadcast_rob_id == tag;
        ld_hit   = ld_broadcast_valid && ld_broadcast_rob_id == tag;
        wake_hit = issue_fire && pick.instr_rob_id == tag;   // producer result lands next cycle
        if (alu_hit || (!ready && ld_hit)) return {1'b1, bypass(tag, data)};
        return {ready || wake_hit, data};
    endfunction

    function automatic iiq_entry_t wake(iiq_entry_t e);
        iiq_entry_t r;
        r = e;
        {r.src1_ready, r.src1_data} = capture(e.src1_rob_id, e.src1_ready, e.src1_data);
        {r.src2_ready, r.src2_data} = capture(e.src2_rob_id, e.src2_ready, e.src2_data);
        return r;
    endfunction

    assign new_entry = '{
        src1_rob_id:  dispatch_src1_rob_id,
        src1_ready:   dispatch_src1_ready || op == ALU_LUI,   // lui reads no register
        src1_data:    dispatch_src1_data,
        src2_used:    src2_used,
        src2_rob_id:  dispatch_src2_rob_id,
        src2_ready:   dispatch_src2_ready,
        src2_data:    dispatch_src2_data,
        instr_rob_id: dispatch_rob_id,
        op:           op,
        imm:          imm,
        use_imm:      use_imm
    };

    always_comb begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            entry_ready[i] = (i < count) && entries[i].src1_ready &&
                             (entries[i].src2_ready || !entries[i].src2_used);
        end
    end

    assign sel_onehot = entry_ready & (~entry_ready + 1'b1);   // lowest set bit
    assign issue_fire = |sel_onehot;

    always_comb begin
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            seen          = seen || sel_onehot[i];
            shift_down[i] = seen;   // entries at and above the pick move down
        end
    end

    always_comb begin
        pick = '0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (sel_onehot[i]) pick = entries[i];
        end
    end

    assign dispatch_ready = count != CNT_W'(N_ENTRIES);
    assign dispatch_fire  = dispatch_valid && dispatch_ready && !fetch_redirect_valid;
    assign wr_idx         = count - CNT_W'(issue_fire);

    always_comb begin
        for (int i = 0; i < N_ENTRIES; i++) begin
            // top slot wraps on a shift but then sits above the count
            entries_next[i] = wake(shift_down[i] ? entries[(i + 1) % N_ENTRIES] : entries[i]);
            if (dispatch_fire && i == wr_idx) entries_next[i] = wake(new_entry);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count     <= '0;
            exe_valid <= 1'b0;
        end else if (fetch_redirect_valid) begin
            count     <= '0;
            exe_valid <= 1'b0;
        end else begin
            count     <= wr_idx + CNT_W'(dispatch_fire);
            exe_valid <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        entries     <= entries_next;
        exe_rob_id  <= pick.instr_rob_id;
        exe_op      <= pick.op;
        exe_src1    <= bypass(pick.src1_rob_id, pick.src1_data);
        exe_src2    <= bypass(pick.src2_rob_id, pick.src2_data);
        exe_imm     <= pick.imm;
        exe_use_imm <= pick.use_imm;
    end

    a_sel_onehot0: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(sel_onehot));
    a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= CNT_W'(N_ENTRIES));
    // a held dispatch must not push the count past full
    a_full_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dispatch_valid && !dispatch_ready && !issue_fire && !fetch_redirect_valid
        |=> !dispatch_ready);

endmodule

//--- verilog/int_pkg.sv
package int_pkg;

    localparam int XLEN         = 32;
    localparam int ROB_ID_WIDTH = 5;

    typedef logic [ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [XLEN-1:0]         reg_data_t;

    // one code per supported operation, immediate forms kept apart
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_ADDI,
        ALU_SLTI,
        ALU_SLTIU,
        ALU_XORI,
        ALU_ORI,
        ALU_ANDI,
        ALU_SLLI,
        ALU_SRLI,
        ALU_SRAI,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same 32 bits, read as register or immediate format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        rob_id_t   src1_rob_id;
        logic      src1_ready;
        reg_data_t src1_data;
        logic      src2_used;
        rob_id_t   src2_rob_id;
        logic      src2_ready;
        reg_data_t src2_data;
        rob_id_t   instr_rob_id;
        alu_op_e   op;
        reg_data_t imm;
        logic      use_imm;
    } iiq_entry_t;

endpackage

//--- verilog/int_result.sv
module int_result import int_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      fetch_redirect_valid,
    input  logic      alu_broadcast_valid,
    input  rob_id_t   alu_broadcast_rob_id,
    input  reg_data_t alu_broadcast_data,
    output logic      result_valid,
    output rob_id_t   result_rob_id,
    output reg_data_t result_data
);

    // completion to the rob, squashed on redirect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= alu_broadcast_valid && !fetch_redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        result_rob_id <= alu_broadcast_rob_id;
        result_data   <= alu_broadcast_data;
    end

    // each rob id issues once, so back-to-back repeats mean a double issue upstream
    a_no_repeat: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid && $past(result_valid) |-> result_rob_id != $past(result_rob_id));

endmodule
